/* rv_pkg.sv */
package rv_pkg;

  localparam int xlen       = 32;
  localparam int reg_addr_w = 5;

  typedef logic [xlen-1:0]       word_t;
  typedef logic [reg_addr_w-1:0] reg_idx_t;

  // major opcodes, bits [6:0]
  localparam logic [6:0] op_lui     = 7'b0110111;
  localparam logic [6:0] op_reg_imm = 7'b0010011;
  localparam logic [6:0] op_reg_reg = 7'b0110011;
  localparam logic [6:0] op_branch  = 7'b1100011;
  localparam logic [6:0] op_environ = 7'b1110011;

  // funct7 patterns for the alu groups
  localparam logic [6:0] f7_base = 7'b0000000;
  localparam logic [6:0] f7_alt  = 7'b0100000;  // sub, sra, srai

  // alu funct3
  localparam logic [2:0] f3_add_sub = 3'b000;
  localparam logic [2:0] f3_sll     = 3'b001;
  localparam logic [2:0] f3_slt     = 3'b010;
  localparam logic [2:0] f3_sltu    = 3'b011;
  localparam logic [2:0] f3_xor     = 3'b100;
  localparam logic [2:0] f3_srl_sra = 3'b101;
  localparam logic [2:0] f3_or      = 3'b110;
  localparam logic [2:0] f3_and     = 3'b111;

  // branch funct3, 010 and 011 are reserved
  localparam logic [2:0] f3_beq  = 3'b000;
  localparam logic [2:0] f3_bne  = 3'b001;
  localparam logic [2:0] f3_blt  = 3'b100;
  localparam logic [2:0] f3_bge  = 3'b101;
  localparam logic [2:0] f3_bltu = 3'b110;
  localparam logic [2:0] f3_bgeu = 3'b111;

  typedef enum logic [3:0] {
    alu_add, alu_sub,
    alu_sll, alu_srl, alu_sra,
    alu_slt, alu_sltu,
    alu_xor, alu_or, alu_and,
    alu_pass_b  // second operand straight through, used by lui
  } alu_op_t;

endpackage

/* rv_decoder.sv */
`timescale 1ns/1ps

module rv_decoder import rv_pkg::*; (
  input  word_t    insn,
  output reg_idx_t rs1,
  output reg_idx_t rs2,
  output alu_op_t  alu_op,
  output logic     use_imm,
  output logic     wb_en,
  output logic     is_branch,
  output logic     is_ecall,
  output logic     illegal,
  output reg_idx_t rd,
  output logic [2:0] funct3,
  output word_t    imm,
  output word_t    branch_imm
);

  logic [6:0] opcode;
  logic [6:0] funct7;
  word_t      imm_i;
  word_t      imm_u;
  logic       alu_legal;  // lui or a supported alu encoding

  // fixed field positions
  assign opcode = insn[6:0];
  assign rd     = insn[11:7];
  assign funct3 = insn[14:12];
  assign rs1    = insn[19:15];
  assign rs2    = insn[24:20];
  assign funct7 = insn[31:25];

  assign imm_i = {{(xlen-12){insn[31]}}, insn[31:20]};
  assign imm_u = {insn[31:12], 12'b0};
  // b-type, bit 0 always zero
  assign branch_imm = {{(xlen-12){insn[31]}}, insn[7], insn[30:25], insn[11:8], 1'b0};

  always_comb begin
    alu_op    = alu_add;
    use_imm   = 1'b0;
    imm       = imm_i;
    alu_legal = 1'b0;
    is_branch = 1'b0;
    is_ecall  = 1'b0;
    case (opcode)
      op_lui: begin
        alu_op    = alu_pass_b;
        use_imm   = 1'b1;
        imm       = imm_u;
        alu_legal = 1'b1;
      end
      op_reg_imm: begin
        use_imm   = 1'b1;
        alu_legal = 1'b1;
        case (funct3)
          f3_sll: begin
            alu_op    = alu_sll;
            alu_legal = (funct7 == f7_base);  // shamt[5] must be clear
          end
          f3_slt:  alu_op = alu_slt;
          f3_sltu: alu_op = alu_sltu;
          f3_xor:  alu_op = alu_xor;
          f3_srl_sra: begin
            alu_op    = insn[30] ? alu_sra : alu_srl;
            alu_legal = (funct7 == f7_base) || (funct7 == f7_alt);
          end
          f3_or:   alu_op = alu_or;
          f3_and:  alu_op = alu_and;
          default: alu_op = alu_add;  // addi
        endcase
      end
      op_reg_reg: begin
        // only add/sub and srl/sra have an alternate funct7
        alu_legal = (funct7 == f7_base) ||
                    (funct7 == f7_alt && (funct3 == f3_add_sub || funct3 == f3_srl_sra));
        case (funct3)
          f3_sll:     alu_op = alu_sll;
          f3_slt:     alu_op = alu_slt;
          f3_sltu:    alu_op = alu_sltu;
          f3_xor:     alu_op = alu_xor;
          f3_srl_sra: alu_op = funct7[5] ? alu_sra : alu_srl;
          f3_or:      alu_op = alu_or;
          f3_and:     alu_op = alu_and;
          default:    alu_op = funct7[5] ? alu_sub : alu_add;
        endcase
      end
      op_branch: begin
        is_branch = (funct3 == f3_beq) || (funct3 == f3_bne) ||
                    (funct3 == f3_blt) || (funct3 == f3_bge) ||
                    (funct3 == f3_bltu) || (funct3 == f3_bgeu);
      end
      op_environ: is_ecall = (insn[31:7] == '0);  // ebreak and csr ops fall out as illegal
      default: ;
    endcase
  end

  // x0 is never a write target
  assign wb_en   = alu_legal && (rd != '0);
  assign illegal = !(alu_legal || is_branch || is_ecall);

endmodule

/* rv_regfile.sv */
`timescale 1ns/1ps

module rv_regfile import rv_pkg::*; (
  input  logic     clk,
  input  logic     rst,
  input  logic     we,
  input  reg_idx_t waddr,
  input  reg_idx_t raddr1,
  input  reg_idx_t raddr2,
  input  word_t    wdata,
  output word_t    rdata1,
  output word_t    rdata2
);

  localparam int nregs = 2 ** reg_addr_w;

  word_t regs [1:nregs-1];  // x1..x31, x0 has no storage

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 1; i < nregs; i++) begin
        regs[i] <= '0;
      end
    end else begin
      for (int i = 1; i < nregs; i++) begin
        if (we && waddr == reg_idx_t'(i)) begin
          regs[i] <= wdata;
        end
      end
    end
  end

  // combinational reads, x0 reads as zero
  assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
  assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

endmodule

/* rv_alu.sv */
`timescale 1ns/1ps

module rv_alu import rv_pkg::*; (
  input  alu_op_t op,
  input  word_t   a,
  input  word_t   rs2_val,
  input  word_t   imm,
  input  logic    use_imm,
  output word_t   result
);

  word_t      b;
  logic [4:0] shamt;

  assign b     = use_imm ? imm : rs2_val;
  assign shamt = b[4:0];  // only the low five bits count for shifts

  always_comb begin
    case (op)
      alu_add: begin
        result = a + b;
      end
      alu_sub: begin
        result = a - b;
      end
      alu_sll: begin
        result = a << shamt;
      end
      alu_srl: begin
        result = a >> shamt;
      end
      alu_sra: begin
        result = word_t'($signed(a) >>> shamt);  // sign fill from bit 31
      end
      alu_slt: begin
        result = {{(xlen-1){1'b0}}, ($signed(a) < $signed(b))};
      end
      alu_sltu: begin
        result = {{(xlen-1){1'b0}}, (a < b)};
      end
      alu_xor: begin
        result = a ^ b;
      end
      alu_or: begin
        result = a | b;
      end
      alu_and: begin
        result = a & b;
      end
      alu_pass_b: begin
        result = b;  // lui
      end
      default: begin
        result = '0;
      end
    endcase
  end

endmodule

/* rv_pc_unit.sv */
`timescale 1ns/1ps

module rv_pc_unit import rv_pkg::*; #(
  parameter word_t reset_pc = '0
) (
  input  logic       clk,
  input  logic       rst,
  input  logic       is_branch,
  input  logic       is_ecall,
  input  logic [2:0] funct3,
  input  word_t      rs1_val,
  input  word_t      rs2_val,
  input  word_t      branch_imm,
  output word_t      pc,
  output logic       halt
);

  logic  taken;
  word_t pc_next;

  // branch condition, decoder only raises is_branch for the six valid funct3
  always_comb begin
    case (funct3)
      f3_beq:  taken = (rs1_val == rs2_val);
      f3_bne:  taken = (rs1_val != rs2_val);
      f3_blt:  taken = ($signed(rs1_val) < $signed(rs2_val));
      f3_bge:  taken = ($signed(rs1_val) >= $signed(rs2_val));
      f3_bltu: taken = (rs1_val < rs2_val);
      f3_bgeu: taken = (rs1_val >= rs2_val);
      default: taken = 1'b0;
    endcase
  end

  assign pc_next = (is_branch && taken) ? pc + branch_imm : pc + word_t'(4);

  always_ff @(posedge clk) begin
    if (rst) begin
      pc   <= reset_pc;
      halt <= 1'b0;
    end else if (!halt) begin
      if (is_ecall) begin
        halt <= 1'b1;  // pc stays on the ecall for good
      end else begin
        pc <= pc_next;
      end
    end
  end

endmodule

/* rv_core_top.sv */
`timescale 1ns/1ps

module rv_core_top import rv_pkg::*; #(
  parameter word_t reset_pc = '0
) (
  input  logic     clk,
  input  logic     rst,
  input  word_t    insn,
  output word_t    pc,
  output logic     halt,
  output logic     illegal,
  output logic     wb_valid,
  output reg_idx_t wb_rd,
  output word_t    wb_data
);

  reg_idx_t   rs1_idx;
  reg_idx_t   rs2_idx;
  alu_op_t    alu_op;
  logic       use_imm;
  logic       is_branch;
  logic       is_ecall;
  logic [2:0] funct3;
  word_t      imm;
  word_t      branch_imm;
  word_t      rs1_data;
  word_t      rs2_data;

  rv_decoder u_dec (
    .insn       (insn),
    .rs1        (rs1_idx),
    .rs2        (rs2_idx),
    .alu_op     (alu_op),
    .use_imm    (use_imm),
    .wb_en      (wb_valid),  // also the regfile write enable
    .is_branch  (is_branch),
    .is_ecall   (is_ecall),
    .illegal    (illegal),
    .rd         (wb_rd),
    .funct3     (funct3),
    .imm        (imm),
    .branch_imm (branch_imm)
  );

  rv_regfile u_rf (
    .clk    (clk),
    .rst    (rst),
    .we     (wb_valid),
    .waddr  (wb_rd),
    .raddr1 (rs1_idx),
    .raddr2 (rs2_idx),
    .wdata  (wb_data),
    .rdata1 (rs1_data),
    .rdata2 (rs2_data)
  );

  rv_alu u_alu (
    .op      (alu_op),
    .a       (rs1_data),
    .rs2_val (rs2_data),
    .imm     (imm),
    .use_imm (use_imm),
    .result  (wb_data)
  );

  rv_pc_unit #(
    .reset_pc (reset_pc)
  ) u_pc (
    .clk        (clk),
    .rst        (rst),
    .is_branch  (is_branch),
    .is_ecall   (is_ecall),
    .funct3     (funct3),
    .rs1_val    (rs1_data),
    .rs2_val    (rs2_data),
    .branch_imm (branch_imm),
    .pc         (pc),
    .halt       (halt)
  );

endmodule

/* rv_trace_checker.sv */
`timescale 1ns/1ps

module rv_trace_checker import rv_pkg::*; #(
  parameter int max_writes = 16
) (
  input  logic     clk,
  input  logic     start,
  input  int       test_idx,
  input  word_t    pc,
  input  logic     halt,
  input  logic     illegal,
  input  logic     wb_valid,
  input  reg_idx_t wb_rd,
  input  word_t    wb_data,
  input  int       exp_count,
  input  word_t    exp_halt_pc,
  input  logic     exp_ill_valid,
  input  word_t    exp_ill_pc,
  input  reg_idx_t exp_rd [0:max_writes-1],
  input  word_t    exp_data [0:max_writes-1],
  output logic     done,
  output int       pass_count,
  output int       fail_count
);

  string name;
  int    errors;
  int    n_writes;
  logic  ill_seen;

  task automatic report_mismatch(input string what, input word_t exp_v, input word_t act_v);
    $display("mismatch %s %s: expected %h, actual %h", name, what, exp_v, act_v);
    errors++;
  endtask

  task automatic report_error(input string msg);
    $display("error %s: %s", name, msg);
    errors++;
  endtask

  // one sample per instruction, taken mid low phase
  task automatic check_cycle();
    logic ill_expected;
    ill_expected = exp_ill_valid && (pc == exp_ill_pc);
    if (illegal !== ill_expected) begin
      if (illegal) report_error("illegal raised on a supported instruction");
      else report_error("illegal not raised on the unsupported instruction");
    end
    if (illegal) ill_seen = 1'b1;
    if (wb_valid) begin
      if (n_writes >= exp_count || n_writes >= max_writes) begin
        report_error("register write beyond the expected trace");
      end else begin
        if (wb_rd !== exp_rd[n_writes]) begin
          report_mismatch("rd", {27'b0, exp_rd[n_writes]}, {27'b0, wb_rd});
        end
        if (wb_data !== exp_data[n_writes]) begin
          report_mismatch("data", exp_data[n_writes], wb_data);
        end
      end
      n_writes++;
    end
  endtask

  task automatic check_halt();
    word_t halt_pc;
    if (n_writes != exp_count) begin
      report_mismatch("write count", word_t'(exp_count), word_t'(n_writes));
    end
    if (pc !== exp_halt_pc) report_mismatch("halt pc", exp_halt_pc, pc);
    if (exp_ill_valid && !ill_seen) report_error("illegal instruction never flagged");
    halt_pc = pc;
    repeat (2) begin
      @(negedge clk);
      #1;
      if (wb_valid) report_error("register write after halt");
      if (pc !== halt_pc) report_error("pc moved after halt");
      if (halt !== 1'b1) report_error("halt dropped without reset");
    end
  endtask

  task automatic run_test();
    name = $sformatf("test_%0d", test_idx);
    errors = 0;
    n_writes = 0;
    ill_seen = 1'b0;
    #1;
    if (pc !== '0 || halt !== 1'b0) report_error("pc or halt not at reset values");
    while (halt !== 1'b1) begin
      check_cycle();
      @(negedge clk);
      #1;
    end
    check_halt();
    if (errors == 0) begin
      pass_count++;
      $display("%s: pass", name);
    end else begin
      fail_count++;
      $display("%s: fail with %0d errors", name, errors);
    end
  endtask

  initial begin
    done = 1'b0;
    pass_count = 0;
    fail_count = 0;
    forever begin
      wait (start);
      run_test();
      done = 1'b1;
      wait (!start);
      done = 1'b0;
    end
  end

endmodule

/* tb_rv_core.sv */
`timescale 1ns/1ps

module tb_rv_core import rv_pkg::*; ();

  localparam int stim_depth = 512;
  localparam int prog_depth = 64;
  localparam int max_writes = 16;
  localparam word_t ecall_word = 32'h0000_0073;

  logic     clk;
  logic     rst;
  word_t    insn;
  word_t    pc;
  logic     halt;
  logic     illegal;
  logic     wb_valid;
  reg_idx_t wb_rd;
  word_t    wb_data;

  logic [31:0] stim [0:stim_depth-1];
  word_t       prog [0:prog_depth-1];
  reg_idx_t    exp_rd [0:max_writes-1];
  word_t       exp_data [0:max_writes-1];
  int          exp_count;
  word_t       exp_halt_pc;
  logic        exp_ill_valid;
  word_t       exp_ill_pc;

  int   test_idx;
  logic start;
  logic done;
  int   pass_count;
  int   fail_count;
  int   load_errors;
  int   rec_ptr;
  int   cycle_count = 0;
  int   cycle_limit = 0;

  rv_core_top #(.reset_pc('0)) UUT (
    .clk(clk), .rst(rst), .insn(insn), .pc(pc), .halt(halt), .illegal(illegal),
    .wb_valid(wb_valid), .wb_rd(wb_rd), .wb_data(wb_data)
  );

  rv_trace_checker #(.max_writes(max_writes)) chk (
    .clk(clk), .start(start), .test_idx(test_idx),
    .pc(pc), .halt(halt), .illegal(illegal), .wb_valid(wb_valid),
    .wb_rd(wb_rd), .wb_data(wb_data),
    .exp_count(exp_count), .exp_halt_pc(exp_halt_pc),
    .exp_ill_valid(exp_ill_valid), .exp_ill_pc(exp_ill_pc),
    .exp_rd(exp_rd), .exp_data(exp_data),
    .done(done), .pass_count(pass_count), .fail_count(fail_count)
  );

  initial clk = 1'b0;
  always #2 clk = ~clk;

  // fetch model, everything past the program reads as ecall
  always @(negedge clk) begin
    if (pc[31:8] == '0) insn <= prog[pc[7:2]];
    else insn <= ecall_word;
  end

  always @(posedge clk) begin
    if (cycle_limit > 0) begin
      cycle_count <= cycle_count + 1;
      if (cycle_count >= cycle_limit) begin
        $display("error: run did not finish within %0d cycles", cycle_limit);
        $display("CHECKS FAILED");
        $finish;
      end
    end
  end

  // 4 cycles per program word plus 10 per test for reset
  function automatic int limit_from_records();
    int p;
    int len;
    int n;
    int total;
    p = 0;
    total = 0;
    while (p < stim_depth - 2 && stim[p] != '0) begin
      len = {20'b0, stim[p][31:20]};
      n = {20'b0, stim[p][19:8]};
      total += 4 * len + 10;
      p += 2 + len + 2 * n;
    end
    return total;
  endfunction

  task automatic load_test(input int p, output int next_p);
    logic [31:0] hdr;
    int len;
    int q;
    hdr = stim[p];
    len = {20'b0, hdr[31:20]};
    exp_count = {20'b0, hdr[19:8]};
    exp_ill_valid = (hdr[7:0] != 8'd0);
    exp_ill_pc = {22'b0, hdr[7:0] - 8'd1, 2'b00};  // marker is word index plus one
    exp_halt_pc = stim[p+1];
    if (len > prog_depth || exp_count > max_writes) begin
      $display("error: record at word %0d does not fit the testbench arrays", p);
      load_errors++;
    end
    for (int i = 0; i < prog_depth; i++) begin
      prog[i] = (i < len) ? stim[p+2+i] : ecall_word;
    end
    q = p + 2 + len;
    for (int i = 0; i < exp_count && i < max_writes; i++) begin
      exp_rd[i] = stim[q+2*i][4:0];
      exp_data[i] = stim[q+2*i+1];
    end
    next_p = q + 2 * exp_count;
  endtask

  initial begin
    rst = 1'b1;
    insn = ecall_word;
    start = 1'b0;
    test_idx = 0;
    load_errors = 0;
    rec_ptr = 0;
    exp_count = 0;
    exp_halt_pc = '0;
    exp_ill_valid = 1'b0;
    exp_ill_pc = '0;
    for (int i = 0; i < prog_depth; i++) prog[i] = ecall_word;
    for (int i = 0; i < max_writes; i++) begin
      exp_rd[i] = '0;
      exp_data[i] = '0;
    end
    for (int i = 0; i < stim_depth; i++) stim[i] = '0;
    $readmemh("rv_core_stimulus.hex", stim);
    cycle_limit = limit_from_records();

    while (rec_ptr < stim_depth - 2 && stim[rec_ptr] != '0) begin
      load_test(rec_ptr, rec_ptr);
      @(negedge clk);
      rst = 1'b1;
      repeat (5) @(negedge clk);
      rst = 1'b0;
      start = 1'b1;  // checker samples this cycle already
      while (!done) @(negedge clk);
      start = 1'b0;
      test_idx++;
    end

    if (test_idx == 0) begin
      $display("error: stimulus file holds no tests");
      load_errors++;
    end
    $display("tests passed: %0d, failed: %0d", pass_count, fail_count + load_errors);
    if (fail_count == 0 && load_errors == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

/* rv_core_stimulus.hex */
// record: header {len[31:20], writes[19:8], illegal word index + 1 [7:0]},
// halt pc, program words, then (rd, value) pairs; a zero header ends the file
// test_0 register-immediate group
00B00A00 00000028
FFB00093 0010A113 0010B193 0F00C213 12306293 FF00F313
00429393 01C0D413 4010D493 FFF2A513 00000073
00000001 FFFFFFFB 00000002 00000001 00000003 00000000 00000004 FFFFFF0B
00000005 00000123 00000006 FFFFFFF0 00000007 00001230 00000008 0000000F
00000009 FFFFFFFD 0000000A 00000000
// test_1 register-register group
00E00D00 00000034
800000B7 00100113 FFD00193 0020A233 0020B2B3 00308333 403103B3
00219433 0070D4B3 4070D533 0021C5B3 0020E633 0071F6B3 00000073
00000001 80000000 00000002 00000001 00000003 FFFFFFFD 00000004 00000001
00000005 00000000 00000006 7FFFFFFD 00000007 00000004 00000008 FFFFFFFA
00000009 08000000 0000000A F8000000 0000000B FFFFFFFC 0000000C 80000001
0000000D 00000004
// test_2 lui, x0 targets and an illegal load at word 4
00700305 00000018
123450B7 00708013 ABCDE037 00100133 0000A183 7FF00213 00000073
00000001 12345000 00000002 12345000 00000004 000007FF
// test_3 six branch conditions taken and not taken
01B00800 00000068
FFF00093 00100113
00108463 00100A13 00109463 00200A13 0020C463 00300A13
0020D463 00400A13 0020E463 00500A13 0020F463 00600A13
00208463 00700A13 00209463 00800A13 00114463 00900A13
00115463 00A00A13 00116463 00B00A13 00117463 00C00A13
00000073
00000001 FFFFFFFF 00000002 00000001 00000014 00000002 00000014 00000004
00000014 00000005 00000014 00000007 00000014 00000009 00000014 0000000C
// test_4 backward branch loop, three passes
00500700 00000010
00300093 FFF08093 00510113 FE009CE3 00000073
00000001 00000003 00000001 00000002 00000002 00000005 00000001 00000001
00000002 0000000A 00000001 00000000 00000002 0000000F
00000000

/* rv_core.f */
rv_pkg.sv
rv_decoder.sv
rv_regfile.sv
rv_alu.sv
rv_pc_unit.sv
rv_core_top.sv
rv_trace_checker.sv
tb_rv_core.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the rv_core testbench with verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f rv_core.f --top-module tb_rv_core -o sim_rv_core
build_status=$?
if [ $build_status -ne 0 ]; then
  echo "verilator build failed with status $build_status"
  exit 1
fi

./obj_dir/sim_rv_core > sim.log 2>&1
sim_status=$?
cat sim.log
if [ $sim_status -ne 0 ]; then
  echo "simulation exited with status $sim_status"
  exit 1
fi

if grep -q "ALL CHECKS PASSED" sim.log; then
  exit 0
else
  echo "pass message not found in sim.log"
  exit 1
fi
